/* source/rvPkg.sv */
package rvPkg;

    // ############################################################
    // Data widths
    // ############################################################
    typedef logic [31:0] word_t;     // Register, ALU and memory data
    typedef logic [31:0] addr_t;     // Byte address
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  regIdx_t;

    localparam int    NUM_REGS = 32;
    localparam addr_t RESET_PC = 32'h0000_0000;

    // ############################################################
    // Opcodes
    // ############################################################
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    // Function codes
    localparam logic [2:0] F3_ADD  = 3'b000;     // Also sub, addi, jalr
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_SW   = 3'b010;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;

    // ############################################################
    // Control codes
    // ############################################################
    typedef enum logic [2:0] {
        ALU_AND  = 3'b000,
        ALU_OR   = 3'b001,
        ALU_ADD  = 3'b010,
        ALU_XOR  = 3'b011,
        ALU_SLTU = 3'b100,
        ALU_SUB  = 3'b110,
        ALU_SLT  = 3'b111
    } aluOp_t;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011,
        IMM_U = 3'b100
    } immSel_t;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10,
        RES_IMM = 2'b11     // lui
    } resultSel_t;

    typedef enum logic [1:0] {
        PC_PLUS4  = 2'b00,
        PC_TARGET = 2'b01,  // Branch and jal
        PC_ALU    = 2'b10   // jalr
    } pcSel_t;

endpackage

/* source/ctrlIf.sv */
`timescale 1ns/1ps

interface ctrlIf import rvPkg::*; ();

    logic       regWrite;
    logic       memWrite;
    logic       aluSrc;      // 1 selects the immediate
    aluOp_t     aluControl;
    immSel_t    immSrc;
    resultSel_t resultSrc;
    pcSel_t     pcSrc;

    modport drive (
        output regWrite,
        output memWrite,
        output aluSrc,
        output aluControl,
        output immSrc,
        output resultSrc,
        output pcSrc
    );

    modport user (
        input regWrite,
        input memWrite,
        input aluSrc,
        input aluControl,
        input immSrc,
        input resultSrc,
        input pcSrc
    );

endinterface

/* source/controlDecoder.sv */
`timescale 1ns/1ps

module controlDecoder import rvPkg::*; (
    input  logic   rstN,
    input  instr_t instr,
    input  logic   zero,
    input  logic   lessThan,
    ctrlIf.drive   ctrl
);

    logic [6:0] opcode;
    logic [2:0] func3;
    logic       func7b5;

    assign opcode  = instr[6:0];
    assign func3   = instr[14:12];
    assign func7b5 = instr[30];    // Picks sub over add

    // ############################################################
    // Decode table
    // ############################################################
    always_comb begin
        ctrl.regWrite   = 1'b0;
        ctrl.memWrite   = 1'b0;
        ctrl.aluSrc     = 1'b0;
        ctrl.aluControl = ALU_ADD;
        ctrl.immSrc     = IMM_I;
        ctrl.resultSrc  = RES_ALU;
        ctrl.pcSrc      = PC_PLUS4;

        case (opcode)
            OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                case (func3)
                    F3_ADD:  ctrl.aluControl = func7b5 ? ALU_SUB : ALU_ADD;
                    F3_SLT:  ctrl.aluControl = ALU_SLT;
                    F3_SLTU: ctrl.aluControl = ALU_SLTU;
                    F3_OR:   ctrl.aluControl = ALU_OR;
                    F3_AND:  ctrl.aluControl = ALU_AND;
                    default: ctrl.regWrite   = 1'b0;     // R-type xor not supported
                endcase
            end
            OP_IMM: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                case (func3)
                    F3_ADD:  ctrl.aluControl = ALU_ADD;
                    F3_SLT:  ctrl.aluControl = ALU_SLT;
                    F3_SLTU: ctrl.aluControl = ALU_SLTU;
                    F3_XOR:  ctrl.aluControl = ALU_XOR;
                    F3_OR:   ctrl.aluControl = ALU_OR;
                    default: ctrl.regWrite   = 1'b0;     // Shifts and andi
                endcase
            end
            OP_LOAD: begin
                ctrl.aluSrc    = 1'b1;
                ctrl.resultSrc = RES_MEM;
                ctrl.regWrite  = (func3 == F3_LW);
            end
            OP_STORE: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = IMM_S;
                ctrl.memWrite = (func3 == F3_SW);
            end
            OP_JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSrc    = IMM_J;
                ctrl.resultSrc = RES_PC4;
                ctrl.pcSrc     = PC_TARGET;
            end
            OP_JALR: begin
                if (func3 == F3_ADD) begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrc    = 1'b1;
                    ctrl.resultSrc = RES_PC4;
                    ctrl.pcSrc     = PC_ALU;
                end
            end
            OP_BRANCH: begin
                ctrl.immSrc     = IMM_B;
                ctrl.aluControl = ALU_SUB;
                case (func3)
                    F3_BEQ:  ctrl.pcSrc = zero      ? PC_TARGET : PC_PLUS4;
                    F3_BNE:  ctrl.pcSrc = !zero     ? PC_TARGET : PC_PLUS4;
                    F3_BLT:  ctrl.pcSrc = lessThan  ? PC_TARGET : PC_PLUS4;
                    F3_BGE:  ctrl.pcSrc = !lessThan ? PC_TARGET : PC_PLUS4;
                    default: ctrl.pcSrc = PC_PLUS4;
                endcase
            end
            OP_LUI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSrc    = IMM_U;
                ctrl.resultSrc = RES_IMM;
            end
            default: begin
                ctrl.regWrite = 1'b0;     // Unknown opcode falls through to pc + 4
            end
        endcase

        // No state changes while the core sits in reset
        if (!rstN) begin
            ctrl.regWrite = 1'b0;
            ctrl.memWrite = 1'b0;
        end
    end

endmodule

/* source/immGen.sv */
`timescale 1ns/1ps

module immGen import rvPkg::*; (
    input  instr_t  instr,
    input  immSel_t immSrc,
    output word_t   imm
);

    logic sgn;

    assign sgn = instr[31];

    always_comb begin
        case (immSrc)
            IMM_I: imm = {{20{sgn}}, instr[31:20]};
            IMM_S: imm = {{20{sgn}}, instr[31:25], instr[11:7]};
            IMM_B: begin
                imm = {{19{sgn}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            IMM_J: begin
                imm = {{11{sgn}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            IMM_U:   imm = {instr[31:12], 12'b0};     // Upper 20 bits, low zeros
            default: imm = {{20{sgn}}, instr[31:20]};
        endcase
    end

endmodule

/* source/regFile.sv */
`timescale 1ns/1ps

module regFile import rvPkg::*; (
    input  logic    clk,
    input  regIdx_t rs1,
    input  regIdx_t rs2,
    input  regIdx_t rd,
    ctrlIf.user     ctrl,
    input  word_t   wData,
    output word_t   rs1Data,
    output word_t   rs2Data
);

    word_t regs [NUM_REGS];

    logic wrEn;

    assign wrEn = ctrl.regWrite && (rd != '0);     // x0 never written

    always_ff @(posedge clk) begin
        if (wrEn) begin
            regs[rd] <= wData;
        end
    end

    // Combinational reads, x0 forced to zero
    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* source/executeUnit.sv */
`timescale 1ns/1ps

module executeUnit import rvPkg::*; (
    ctrlIf.user   ctrl,
    input  word_t rs1Data,
    input  word_t rs2Data,
    input  word_t imm,
    input  addr_t pc,
    input  word_t memRData,
    output word_t aluResult,
    output word_t result,
    output logic  zero,
    output logic  lessThan
);

    word_t srcA;
    word_t srcB;
    logic  ltSigned;
    logic  ltUnsigned;

    assign srcA = rs1Data;
    assign srcB = ctrl.aluSrc ? imm : rs2Data;

    assign ltSigned   = $signed(srcA) < $signed(srcB);
    assign ltUnsigned = srcA < srcB;

    // ############################################################
    // ALU
    // ############################################################
    always_comb begin
        case (ctrl.aluControl)
            ALU_AND:  aluResult = srcA & srcB;
            ALU_OR:   aluResult = srcA | srcB;
            ALU_ADD:  aluResult = srcA + srcB;
            ALU_XOR:  aluResult = srcA ^ srcB;
            ALU_SUB:  aluResult = srcA - srcB;
            ALU_SLT:  aluResult = {31'b0, ltSigned};
            ALU_SLTU: aluResult = {31'b0, ltUnsigned};
            default:  aluResult = '0;
        endcase
    end

    assign zero     = (aluResult == '0);
    assign lessThan = ltSigned;     // Immune to subtraction overflow

    // Write-back select
    always_comb begin
        case (ctrl.resultSrc)
            RES_ALU: result = aluResult;
            RES_MEM: result = memRData;
            RES_PC4: result = pc + 32'd4;     // Link address
            RES_IMM: result = imm;
            default: result = aluResult;
        endcase
    end

endmodule

/* source/pcUnit.sv */
`timescale 1ns/1ps

module pcUnit import rvPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    ctrlIf.user   ctrl,
    input  word_t imm,
    input  word_t aluResult,
    output addr_t pc
);

    addr_t pcNext;
    addr_t pcPlus4;

    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (ctrl.pcSrc)
            PC_PLUS4:  pcNext = pcPlus4;
            PC_TARGET: pcNext = pc + imm;
            PC_ALU:    pcNext = {aluResult[31:1], 1'b0};     // jalr clears bit 0
            default:   pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

/* source/rvCore.sv */
`timescale 1ns/1ps

module rvCore import rvPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    output addr_t  imemAddr,
    input  instr_t imemData,
    output addr_t  dmemAddr,
    output word_t  dmemWData,
    output logic   dmemWe,
    input  word_t  dmemRData
);

    ctrlIf ctrlBus ();

    addr_t pc;
    word_t imm;
    word_t rs1Data;
    word_t rs2Data;
    word_t aluResult;
    word_t result;
    logic  zero;
    logic  lessThan;

    // ############################################################
    // Units
    // ############################################################
    controlDecoder uDecoder (
        .rstN     (rstN),
        .instr    (imemData),
        .zero     (zero),
        .lessThan (lessThan),
        .ctrl     (ctrlBus.drive)
    );

    immGen uImmGen (
        .instr  (imemData),
        .immSrc (ctrlBus.immSrc),
        .imm    (imm)
    );

    regFile uRegFile (
        .clk     (clk),
        .rs1     (imemData[19:15]),
        .rs2     (imemData[24:20]),
        .rd      (imemData[11:7]),
        .ctrl    (ctrlBus.user),
        .wData   (result),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    executeUnit uExecute (
        .ctrl      (ctrlBus.user),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .imm       (imm),
        .pc        (pc),
        .memRData  (dmemRData),
        .aluResult (aluResult),
        .result    (result),
        .zero      (zero),
        .lessThan  (lessThan)
    );

    pcUnit uPc (
        .clk       (clk),
        .rstN      (rstN),
        .ctrl      (ctrlBus.user),
        .imm       (imm),
        .aluResult (aluResult),
        .pc        (pc)
    );

    assign imemAddr  = pc;
    assign dmemAddr  = aluResult;     // Base plus offset
    assign dmemWData = rs2Data;
    assign dmemWe    = ctrlBus.memWrite;

endmodule

/* verif/tbCore.sv */
`timescale 1ns/1ps

module tbCore import rvPkg::*; ();

    localparam int      IMEM_WORDS  = 512;
    localparam int      DMEM_WORDS  = 256;
    localparam int      PROG_LEN    = 200;
    localparam int      BODY_BASE   = 62;     // After 31 lui/addi pairs
    localparam int      BODY_END    = BODY_BASE + PROG_LEN;
    localparam int      RESET_CYC   = 8;
    localparam int      CYCLE_LIMIT = 2 * (PROG_LEN + 31 + 16) + RESET_CYC;
    localparam instr_t  HALT        = 32'h0000_006f;     // jal x0, 0
    localparam instr_t  RESET_SW    = 32'h0010_2223;     // sw x1, 4(x0)
    localparam logic [6:0] OP_BAD   = 7'b0001011;

    logic   clk;
    logic   rstN;
    addr_t  imemAddr;
    instr_t imemData;
    addr_t  dmemAddr;
    word_t  dmemWData;
    logic   dmemWe;
    word_t  dmemRData;

    instr_t imem [IMEM_WORDS];
    word_t  dmem [DMEM_WORDS];
    word_t  mDmem [DMEM_WORDS];
    word_t  mReg [32];
    addr_t  mPc;
    logic   expWe;
    addr_t  expAddr;
    word_t  expData;

    logic [31:0] seed = 32'hafb58aed;
    int errCount   = 0;
    int checkCount = 0;
    int cycleCount = 0;

    rvCore dut0 (
        .clk       (clk),
        .rstN      (rstN),
        .imemAddr  (imemAddr),
        .imemData  (imemData),
        .dmemAddr  (dmemAddr),
        .dmemWData (dmemWData),
        .dmemWe    (dmemWe),
        .dmemRData (dmemRData)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ############################################################
    // Memory models
    // ############################################################
    // A store sits on the instruction bus while in reset
    assign imemData  = rstN ? imem[imemAddr[10:2]] : RESET_SW;
    assign dmemRData = dmem[dmemAddr[9:2]];

    always @(posedge clk) begin
        if (dmemWe) begin
            dmem[dmemAddr[9:2]] <= dmemWData;
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, core never reached the halt", cycleCount);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Instruction encoders
    function automatic instr_t encR(logic f7b5, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3, logic [4:0] rd);
        return {1'b0, f7b5, 5'b0, rs2, rs1, f3, rd, OP_RTYPE};
    endfunction

    function automatic instr_t encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                    logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instr_t encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OP_STORE};
    endfunction

    function automatic instr_t encB(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic instr_t encJ(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    // ############################################################
    // Random program
    // ############################################################
    task automatic buildProgram();
        int pc;
        int k;
        int target;
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0] rr;
        logic [4:0] t;
        logic [2:0] f3Tab [6];
        pc = 0;
        for (int i = 0; i < IMEM_WORDS; i++) imem[i] = '0;
        for (int i = 1; i < 32; i++) begin
            r = nextRand();
            rr = i[4:0];
            imem[pc] = {r[31:12], rr, OP_LUI};
            imem[pc + 1] = encI(r[11:0], rr, F3_ADD, rr, OP_IMM);
            pc = pc + 2;
        end
        while (pc < BODY_END) begin
            r = nextRand();
            r2 = nextRand();
            k = int'(r2 % 16) + 1;
            if (pc + k > BODY_END) k = BODY_END - pc;
            case (r % 10)
                0, 1, 2: begin
                    f3Tab = '{F3_ADD, F3_ADD, F3_SLT, F3_SLTU, F3_OR, F3_AND};
                    imem[pc] = encR(r2 % 6 == 1, r[24:20], r[19:15],     // Slot 1 is sub
                                    f3Tab[r2 % 6], r[11:7]);
                end
                3, 4: begin
                    f3Tab = '{F3_ADD, F3_SLT, F3_SLTU, F3_XOR, F3_OR, F3_ADD};
                    imem[pc] = encI(r2[31:20], r[19:15], f3Tab[r2 % 5], r[11:7], OP_IMM);
                end
                5: imem[pc] = encI(12'(4 * (r2 % 64)), 5'd0, F3_LW, r[11:7], OP_LOAD);
                6: imem[pc] = encS(12'(4 * (r2 % 64)), r[24:20], 5'd0);
                7: begin
                    f3Tab = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BEQ, F3_BEQ};
                    imem[pc] = encB(13'(4 * k), r[24:20], r[19:15], f3Tab[(r2 >> 4) % 4]);
                end
                8: begin
                    if (r[31] && pc + 3 <= BODY_END) begin
                        target = pc + 3 + int'(r2 % 8);
                        if (target > BODY_END) target = BODY_END;
                        t = (r[19:15] == 5'd0) ? 5'd1 : r[19:15];
                        imem[pc] = {20'd0, t, OP_LUI};
                        imem[pc + 1] = encI(12'(target * 4 + 1), t, F3_ADD, t, OP_IMM);
                        imem[pc + 2] = encI(12'd0, t, F3_ADD, r[11:7], OP_JALR);
                        pc = pc + 2;
                    end else begin
                        imem[pc] = encJ(21'(4 * k), r[11:7]);
                    end
                end
                default: imem[pc] = {r2[31:7], OP_BAD};
            endcase
            pc = pc + 1;
        end
        for (int i = 1; i < 32; i++) begin
            rr = i[4:0];
            imem[pc] = encS(12'(256 + 4 * i), rr, 5'd0);
            pc = pc + 1;
        end
        imem[pc] = HALT;
    endtask

    // ############################################################
    // Reference model, one instruction per call
    // ############################################################
    task automatic modelStep();
        instr_t in;
        word_t  a;
        word_t  b;
        word_t  res;
        word_t  iImm;
        word_t  sImm;
        word_t  bImm;
        word_t  jImm;
        logic   wr;
        logic   taken;
        addr_t  nextPc;
        in    = imem[mPc[10:2]];
        a     = mReg[in[19:15]];
        b     = mReg[in[24:20]];
        iImm  = {{20{in[31]}}, in[31:20]};
        sImm  = {{20{in[31]}}, in[31:25], in[11:7]};
        bImm  = {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
        jImm  = {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
        wr    = 1'b0;
        res   = '0;
        taken = 1'b0;
        expWe = 1'b0;
        nextPc = mPc + 4;
        case (in[6:0])
            OP_RTYPE: begin
                wr = 1'b1;
                case (in[14:12])
                    3'b000:  res = in[30] ? a - b : a + b;
                    3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                    3'b011:  res = {31'b0, a < b};
                    3'b110:  res = a | b;
                    3'b111:  res = a & b;
                    default: wr = 1'b0;
                endcase
            end
            OP_IMM: begin
                wr = 1'b1;
                case (in[14:12])
                    3'b000:  res = a + iImm;
                    3'b010:  res = {31'b0, $signed(a) < $signed(iImm)};
                    3'b011:  res = {31'b0, a < iImm};
                    3'b100:  res = a ^ iImm;
                    3'b110:  res = a | iImm;
                    default: wr = 1'b0;
                endcase
            end
            OP_LOAD: begin
                wr  = (in[14:12] == 3'b010);
                res = mDmem[8'((a + iImm) >> 2)];
            end
            OP_STORE: begin
                if (in[14:12] == 3'b010) begin
                    expWe   = 1'b1;
                    expAddr = a + sImm;
                    expData = b;
                    mDmem[8'(expAddr >> 2)] = b;
                end
            end
            OP_BRANCH: begin
                case (in[14:12])
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = $signed(a) < $signed(b);
                    3'b101:  taken = !($signed(a) < $signed(b));
                    default: taken = 1'b0;
                endcase
                if (taken) nextPc = mPc + bImm;
            end
            OP_JAL: begin
                wr = 1'b1;
                res = mPc + 4;
                nextPc = mPc + jImm;
            end
            OP_JALR: begin
                if (in[14:12] == 3'b000) begin
                    wr = 1'b1;
                    res = mPc + 4;
                    nextPc = (a + iImm) & ~32'd1;
                end
            end
            OP_LUI: begin
                wr = 1'b1;
                res = {in[31:12], 12'b0};
            end
            default: wr = 1'b0;     // Unknown opcode
        endcase
        if (wr && in[11:7] != 5'd0) mReg[in[11:7]] = res;
        mPc = nextPc;
    endtask

    task automatic checkValue(string name, logic [31:0] expVal, logic [31:0] gotVal);
        checkCount = checkCount + 1;
        if (expVal !== gotVal) begin
            errCount = errCount + 1;
            $display("Mismatch %s expected %h got %h", name, expVal, gotVal);
        end
    endtask

    // ############################################################
    // Main sequence
    // ############################################################
    initial begin
        logic halted;
        rstN = 1'b0;
        buildProgram();
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]  = (i * 32'h9e37_79b1) ^ 32'h5a5a_0000 ^ (i << 20);
            mDmem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) mReg[i] = '0;
        mPc = RESET_PC;

        for (int i = 0; i < RESET_CYC; i++) begin
            @(negedge clk);
            checkValue("dmemWe", 32'(1'b0), 32'(dmemWe));
            checkValue("imemAddr", 32'd0, imemAddr);
            @(posedge clk);
        end
        #1 rstN = 1'b1;

        halted = 1'b0;
        while (!halted) begin
            @(negedge clk);
            checkValue("imemAddr", mPc, imemAddr);
            halted = (imem[mPc[10:2]] == HALT);
            modelStep();
            checkValue("dmemWe", 32'(expWe), 32'(dmemWe));
            if (expWe) begin
                checkValue("dmemAddr", expAddr, dmemAddr);
                checkValue("dmemWData", expData, dmemWData);
            end
        end

        $display("Checks %0d, errors %0d, cycles %0d", checkCount, errCount, cycleCount);
        if (errCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verif/rvCore_assertions.sv */
`timescale 1ns/1ps

module rvCoreAssertions import rvPkg::*; (
    input logic   clk,
    input logic   rstN,
    input addr_t  imemAddr,
    input instr_t imemData,
    input logic   dmemWe
);

    logic flowOp;

    assign flowOp = (imemData[6:0] == OP_BRANCH) || (imemData[6:0] == OP_JAL) ||
                    (imemData[6:0] == OP_JALR);

    weKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(dmemWe))
        else $error("dmemWe unknown");

    pcAligned: assert property (@(posedge clk) imemAddr[1:0] == 2'b00)
        else $error("imemAddr not word aligned");

    // Straight-line code steps by one word
    pcStep: assert property (@(posedge clk) disable iff (!rstN)
        !flowOp |=> imemAddr == $past(imemAddr) + 32'd4)
        else $error("PC did not advance by 4");

endmodule

bind rvCore rvCoreAssertions chk0 (
    .clk      (clk),
    .rstN     (rstN),
    .imemAddr (imemAddr),
    .imemData (imemData),
    .dmemWe   (dmemWe)
);

/* tb.f */
source/rvPkg.sv
source/ctrlIf.sv
source/controlDecoder.sv
source/immGen.sv
source/regFile.sv
source/executeUnit.sv
source/pcUnit.sv
source/rvCore.sv
verif/tbCore.sv
verif/rvCore_assertions.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tbCore \
    -f tb.f \
    -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

# Pass only when the testbench reported success
grep -q "Result: PASSED" sim.log
